// ==== logic/modmul_settings.svh ====
`ifndef MODMUL_SETTINGS_SVH
`define MODMUL_SETTINGS_SVH

// width of one operand word in bits
`define MM_WORD_W 8

// number of words in the accumulator and in every operand
`define MM_N_WORDS 4

// the modulus is 2^(MM_N_WORDS*MM_WORD_W - MM_B_OFFSET) - 1
`define MM_B_OFFSET 1

// external memory address width
`define MM_MEM_ADDR_W 9

// first address read by a preload and first address written by a store
`define MM_PRELOAD_BASE 4
`define MM_STORE_BASE 8

`endif

// ==== logic/modmul_pkg.sv ====
`include "modmul_settings.svh"

package modmul_pkg;

    // commands seen on the top level command input, NOP leaves the unit alone
    typedef enum logic [2:0] {
        CMD_NOP          = 3'd0,
        CMD_PRELOAD      = 3'd1,
        CMD_STORE        = 3'd2,
        CMD_RESET_RESULT = 3'd3,
        CMD_MULT         = 3'd4,
        CMD_SQUARE       = 3'd5
    } cmd_t;

    // sequencer states, BUSY covers the whole multiply and fold
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PRELOAD = 2'd1,
        ST_STORE   = 2'd2,
        ST_BUSY    = 2'd3
    } seq_state_t;

    typedef logic [`MM_WORD_W-1:0] word_t;
    typedef word_t [`MM_N_WORDS-1:0] operand_t;

    // a column holds up to N_WORDS double-width products plus the carry rippled in from below
    typedef logic [2*`MM_WORD_W+$clog2(`MM_N_WORDS):0] column_t;
    typedef column_t [2*`MM_N_WORDS-2:0] product_t;

endpackage

// ==== logic/mm_bus_if.sv ====
`timescale 1ns/1ps

interface mm_bus_if;
    import modmul_pkg::*;

    // request from the sequencer, square is only looked at together with start
    logic     start;
    logic     square;
    operand_t operand;

    // full product from the multiply array with the column carries already rippled
    logic     prod_valid;
    product_t prod;

    // reduced value returned to the sequencer
    logic     done;
    operand_t result;

    modport seq (output start, output square, output operand, input done, input result);

    modport mac (input start, input square, input operand, output prod_valid, output prod);

    modport fold (input prod_valid, input prod, output done, output result);

endinterface

// ==== logic/mm_sequencer.sv ====
`timescale 1ns/1ps
`include "modmul_settings.svh"

module mm_sequencer (
    input  logic                      clk,
    input  logic                      aclr,
    input  modmul_pkg::cmd_t          i_cmd,
    input  modmul_pkg::word_t         i_mem_rdata,
    output logic                      o_ready,
    output logic                      o_mem_rden,
    output logic                      o_mem_wren,
    output logic [`MM_MEM_ADDR_W-1:0] o_mem_addr,
    output modmul_pkg::word_t         o_mem_wdata,
    mm_bus_if.seq                     bus
);
    import modmul_pkg::*;

    localparam int N      = `MM_N_WORDS;
    localparam int ADDR_W = `MM_MEM_ADDR_W;
    localparam int CNT_W  = $clog2(N);

    localparam logic [CNT_W-1:0]  LAST_WORD    = CNT_W'(N - 1);
    localparam logic [ADDR_W-1:0] PRELOAD_BASE = ADDR_W'(`MM_PRELOAD_BASE);
    localparam logic [ADDR_W-1:0] STORE_BASE   = ADDR_W'(`MM_STORE_BASE);

    seq_state_t       state_q;
    seq_state_t       state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic             idle;
    operand_t         r_q;
    operand_t         store_q;

    assign idle    = (state_q == ST_IDLE);
    assign o_ready = idle;

    // next state and word count
    // the count restarts at zero every time the machine sits in IDLE
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            ST_IDLE: begin
                cnt_d = '0;
                case (i_cmd)
                    CMD_PRELOAD:          state_d = ST_PRELOAD;
                    CMD_STORE:            state_d = ST_STORE;
                    CMD_MULT, CMD_SQUARE: state_d = ST_BUSY;
                    default:              state_d = ST_IDLE;
                endcase
            end
            ST_PRELOAD, ST_STORE: begin
                // one word per cycle, back to IDLE after the last one
                if (cnt_q == LAST_WORD) begin
                    state_d = ST_IDLE;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            ST_BUSY: begin
                // the fold unit tells us when the new value of r is ready
                if (bus.done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // reads are issued one cycle ahead of the state that consumes them
    // so the address comes from the next count and word 0 lands in the first PRELOAD cycle
    assign o_mem_rden  = (state_d == ST_PRELOAD);
    assign o_mem_wren  = (state_q == ST_STORE);
    assign o_mem_addr  = o_mem_wren ? STORE_BASE + ADDR_W'(cnt_q)
                                    : PRELOAD_BASE + ADDR_W'(cnt_d);
    assign o_mem_wdata = store_q[0];

    // a multiply request goes straight out so the array can load r at the accepting edge
    assign bus.start   = idle && (i_cmd == CMD_MULT || i_cmd == CMD_SQUARE);
    assign bus.square  = (i_cmd == CMD_SQUARE);
    assign bus.operand = r_q;

    // state, count and the accumulator r
    always_ff @(posedge clk or posedge aclr) begin
        if (aclr) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            r_q     <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            if (idle && i_cmd == CMD_RESET_RESULT) begin
                r_q <= operand_t'(1);
            end else if (state_q == ST_PRELOAD) begin
                // read data for word cnt_q arrives in this cycle
                r_q[cnt_q] <= i_mem_rdata;
            end else if (state_q == ST_BUSY && bus.done) begin
                r_q <= bus.result;
            end
        end
    end

    // store shifter, takes a copy of r and hands out the low word first
    always_ff @(posedge clk) begin
        if (idle && i_cmd == CMD_STORE) begin
            store_q <= r_q;
        end else if (state_q == ST_STORE) begin
            store_q <= {word_t'(0), store_q[N-1:1]};
        end
    end

    // the memory port is shared so a read and a write may never overlap
    a_mem_one_dir: assert property (@(posedge clk) disable iff (aclr)
        !(o_mem_rden && o_mem_wren));

    // the fold unit may only answer a request that this sequencer issued
    a_done_in_busy: assert property (@(posedge clk) disable iff (aclr)
        bus.done |-> state_q == ST_BUSY);

endmodule

// ==== logic/mac_array.sv ====
`timescale 1ns/1ps
`include "modmul_settings.svh"

module mac_array (
    input  logic              clk,
    input  logic              aclr,
    input  modmul_pkg::word_t i_t_data,
    mm_bus_if.mac             bus
);
    import modmul_pkg::*;

    localparam int W     = `MM_WORD_W;
    localparam int N     = `MM_N_WORDS;
    localparam int NCOL  = 2*N - 1;
    localparam int COL_W = $bits(column_t);
    localparam int CNT_W = $clog2(N + 2);

    logic             run_q;
    logic             square_q;
    logic [CNT_W-1:0] cnt_q;
    logic             feed;
    logic             gather;
    word_t            x_word;
    operand_t         y_q;
    operand_t         xsh_q;
    column_t          acc_q [N];
    column_t          col_q [NCOL];
    product_t         prod_rip;

    // counts 0..N-1 feed X words, N gathers the open columns, N+1 presents the product
    assign feed           = run_q && (cnt_q < CNT_W'(N));
    assign gather         = run_q && (cnt_q == CNT_W'(N));
    assign bus.prod_valid = run_q && (cnt_q == CNT_W'(N + 1));

    always_ff @(posedge clk or posedge aclr) begin
        if (aclr) begin
            run_q    <= 1'b0;
            square_q <= 1'b0;
            cnt_q    <= '0;
        end else if (bus.start) begin
            run_q    <= 1'b1;
            square_q <= bus.square;
            cnt_q    <= '0;
        end else if (run_q) begin
            if (bus.prod_valid) begin
                run_q <= 1'b0;
            end
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // a square takes X from its own copy of r, a multiply takes it from the T stream
    assign x_word = square_q ? xsh_q[0] : i_t_data;

    // y rotates up by one lane per cycle so lane j sees Y[(j-i) mod N] in feed cycle i
    always_ff @(posedge clk) begin
        if (bus.start) begin
            y_q <= bus.operand;
            if (bus.square) begin
                xsh_q <= bus.operand;
            end
        end else if (feed) begin
            y_q   <= {y_q[N-2:0], y_q[N-1]};
            xsh_q <= {word_t'(0), xsh_q[N-1:1]};
        end
    end

    // lane j builds column j during cycles 0..j and column j+N afterwards
    // it restarts in cycle 0 and again in cycle j+1 once column j has been handed over
    for (genvar j = 0; j < N; j++) begin : g_lane
        logic [2*W-1:0] mul;
        logic           restart;

        assign mul     = x_word * y_q[j];
        assign restart = (cnt_q == '0) || (cnt_q == CNT_W'(j + 1));

        always_ff @(posedge clk) begin
            if (feed) begin
                if (restart) begin
                    acc_q[j] <= column_t'(mul);
                end else begin
                    acc_q[j] <= acc_q[j] + column_t'(mul);
                end
            end
        end
    end

    // low columns are parked as they complete, the rest are picked up in the gather cycle
    always_ff @(posedge clk) begin
        for (int j = 0; j < N - 1; j++) begin
            if (feed && cnt_q == CNT_W'(j + 1)) begin
                col_q[j] <= acc_q[j];
            end
            if (gather) begin
                col_q[N + j] <= acc_q[j];
            end
        end
        if (gather) begin
            col_q[N-1] <= acc_q[N-1];
        end
    end

    // carry ripple, every column but the top one keeps only its low word
    always_comb begin
        column_t              sum;
        logic [COL_W-W-1:0]   carry;
        carry = '0;
        for (int i = 0; i < NCOL; i++) begin
            sum = col_q[i] + column_t'(carry);
            if (i < NCOL - 1) begin
                prod_rip[i] = column_t'(sum[W-1:0]);
            end else begin
                prod_rip[i] = sum;
            end
            carry = sum[COL_W-1:W];
        end
    end

    assign bus.prod = prod_rip;

    // the sequencer must hold off a new request until the current product has been handed on
    a_no_start_while_running: assert property (@(posedge clk) disable iff (aclr)
        bus.start |-> !run_q);

endmodule

// ==== logic/mersenne_fold.sv ====
`timescale 1ns/1ps
`include "modmul_settings.svh"

module mersenne_fold (
    input  logic   clk,
    input  logic   aclr,
    mm_bus_if.fold bus
);
    import modmul_pkg::*;

    localparam int W    = `MM_WORD_W;
    localparam int N    = `MM_N_WORDS;
    localparam int B    = `MM_B_OFFSET;
    localparam int NW   = N * W;
    localparam int M    = NW - B;
    localparam int FW   = 2 * NW;
    localparam int NCOL = 2*N - 1;
    localparam int LVLS = $clog2(N);

    logic [FW-1:0]   flat;
    logic [FW-1:0]   fold_in;
    logic            in_valid;
    logic [NW-1:0]   lo_part;
    logic [FW-M-1:0] hi_part;
    logic [W:0]      sum_a [N];
    logic [B-1:0]    hx_a;
    logic            va_q;
    logic [N-1:0]    word_g;
    logic [N-1:0]    word_p;
    wire  [N-1:0]    pg_g [LVLS+1];
    wire  [N-1:0]    pg_p [LVLS+1];
    logic [N-1:0]    cin;
    operand_t        res_b;
    logic [B:0]      over_b;
    logic            vb_q;
    logic [NW+B:0]   chk;
    logic            above;
    logic            refold_q;
    logic [FW-1:0]   fb_q;
    logic            done_q;
    operand_t        result_q;

    // flatten the rippled columns into one wide number
    // the top column can only be two words wide since the product fits in 2*NW bits
    always_comb begin
        for (int i = 0; i < NCOL - 1; i++) begin
            flat[i*W +: W] = bus.prod[i][W-1:0];
        end
        flat[(NCOL-1)*W +: 2*W] = bus.prod[NCOL-1][2*W-1:0];
    end

    // a second round takes its input from the feedback register instead of the array
    assign in_valid = bus.prod_valid || refold_q;
    assign fold_in  = refold_q ? fb_q : flat;

    // 2^M is one modulo 2^M-1, so the part above bit M is simply added to the part below it
    assign lo_part = NW'(fold_in[M-1:0]);
    assign hi_part = fold_in[FW-1:M];

    // word sums keep one carry bit each while the high part's overflow above NW waits in hx_a
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int k = 0; k < N; k++) begin
                sum_a[k] <= {1'b0, lo_part[k*W +: W]} + {1'b0, hi_part[k*W +: W]};
            end
            hx_a <= hi_part[FW-M-1:NW];
        end
    end

    // a word generates a carry with its ninth bit and passes one on when it is all ones
    always_comb begin
        for (int k = 0; k < N; k++) begin
            word_g[k] = sum_a[k][W];
            word_p[k] = &sum_a[k][W-1:0];
        end
    end

    assign pg_g[0] = word_g;
    assign pg_p[0] = word_p;

    // in the prefix network level l combines each word with the group 2^l words below it
    for (genvar l = 0; l < LVLS; l++) begin : g_level
        for (genvar k = 0; k < N; k++) begin : g_node
            if (k >= (1 << l)) begin : g_merge
                assign pg_g[l+1][k] = pg_g[l][k] | (pg_p[l][k] & pg_g[l][k-(1<<l)]);
                assign pg_p[l+1][k] = pg_p[l][k] & pg_p[l][k-(1<<l)];
            end else begin : g_pass
                assign pg_g[l+1][k] = pg_g[l][k];
                assign pg_p[l+1][k] = pg_p[l][k];
            end
        end
    end

    // carry into word k is the group generate of words 0..k-1
    assign cin = {pg_g[LVLS][N-2:0], 1'b0};

    always_ff @(posedge clk) begin
        if (va_q) begin
            for (int k = 0; k < N; k++) begin
                res_b[k] <= sum_a[k][W-1:0] + W'(cin[k]);
            end
            over_b <= (B+1)'(hx_a) + (B+1)'(pg_g[LVLS][N-1]);
        end
    end

    // anything left at or above bit M needs one more pass through the adder
    assign chk   = {over_b, res_b};
    assign above = |chk[NW+B:M];

    always_ff @(posedge clk) begin
        if (vb_q) begin
            fb_q     <= FW'(chk);
            result_q <= res_b;
        end
    end

    // the valid bits follow the data, and a round takes three cycles from input to done or refold
    always_ff @(posedge clk or posedge aclr) begin
        if (aclr) begin
            va_q     <= 1'b0;
            vb_q     <= 1'b0;
            refold_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            va_q     <= in_valid;
            vb_q     <= va_q;
            refold_q <= vb_q && above;
            done_q   <= vb_q && !above;
        end
    end

    assign bus.done   = done_q;
    assign bus.result = result_q;

    // a second round always brings the value below bit M, so done follows it and no third round runs
    a_result_in_range: assert property (@(posedge clk) disable iff (aclr)
        $past(refold_q, 2) |-> !above);

endmodule

// ==== logic/modmul_top.sv ====
`timescale 1ns/1ps
`include "modmul_settings.svh"

module modmul_top (
    input  logic                      clk,
    input  logic                      aclr,
    input  modmul_pkg::cmd_t          i_cmd,
    output logic                      o_ready,
    input  modmul_pkg::word_t         i_t_data,
    output logic [`MM_MEM_ADDR_W-1:0] o_mem_addr,
    output logic                      o_mem_rden,
    output logic                      o_mem_wren,
    output modmul_pkg::word_t         o_mem_wdata,
    input  modmul_pkg::word_t         i_mem_rdata
);

    // the three blocks talk over one shared bus, each through its own modport
    mm_bus_if bus ();

    // command decode, the accumulator r and the memory port
    mm_sequencer mm_sequencer_inst (
        .clk         (clk),
        .aclr        (aclr),
        .i_cmd       (i_cmd),
        .i_mem_rdata (i_mem_rdata),
        .o_ready     (o_ready),
        .o_mem_rden  (o_mem_rden),
        .o_mem_wren  (o_mem_wren),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .bus         (bus)
    );

    // full product of r with the T stream or with itself
    mac_array mac_array_inst (
        .clk      (clk),
        .aclr     (aclr),
        .i_t_data (i_t_data),
        .bus      (bus)
    );

    // reduction modulo the Mersenne number
    mersenne_fold mersenne_fold_inst (
        .clk  (clk),
        .aclr (aclr),
        .bus  (bus)
    );

endmodule

// ==== bench/modmul_checker.sv ====
`timescale 1ns/1ps
`include "modmul_settings.svh"

module modmul_checker (
    input  logic                      clk,
    input  logic                      aclr,
    input  logic                      i_ready,
    input  logic                      i_mem_rden,
    input  logic                      i_mem_wren,
    input  logic [`MM_MEM_ADDR_W-1:0] i_mem_addr,
    input  modmul_pkg::word_t         i_mem_wdata,
    input  logic [8*24-1:0]           i_name,
    input  logic [31:0]               i_expected,
    output int                        o_checks,
    output int                        o_fails
);
    import modmul_pkg::*;

    // the fold may hand back the modulus itself in place of zero
    localparam logic [31:0] MODULUS = 32'h7fff_ffff;

    int          checks = 0;
    int          fails = 0;
    int          idx = 0;
    logic        reset_seen = 1'b0;
    logic [31:0] collected = '0;

    assign o_checks = checks;
    assign o_fails  = fails;

    // everything is sampled on the falling edge half a cycle away from any DUT update
    always @(negedge clk) begin
        if (!aclr) begin
            // the very first cycle out of reset must show an idle unit
            if (!reset_seen) begin
                reset_seen = 1'b1;
                checks++;
                if (i_ready && !i_mem_rden && !i_mem_wren) begin
                    $display("ok %0s", "reset_state");
                end else begin
                    fails++;
                    $display("ERROR reset_state expected ready/rden/wren 100 actual %0b%0b%0b",
                             i_ready, i_mem_rden, i_mem_wren);
                end
            end
            if (i_mem_wren) begin
                // store words come low first at consecutive addresses
                if (i_mem_addr != 9'(`MM_STORE_BASE + idx)) begin
                    fails++;
                    $display("ERROR %0s expected address %0d actual %0d",
                             i_name, 9'(`MM_STORE_BASE + idx), i_mem_addr);
                end
                collected[idx*8 +: 8] = i_mem_wdata;
                if (idx == `MM_N_WORDS - 1) begin
                    idx = 0;
                    checks++;
                    if (collected == i_expected || collected == i_expected + MODULUS) begin
                        $display("ok %0s stored %08h", i_name, collected);
                    end else begin
                        fails++;
                        $display("ERROR %0s expected %08h actual %08h",
                                 i_name, i_expected, collected);
                    end
                end else begin
                    idx++;
                end
            end
        end
    end

endmodule

// ==== bench/modmul_tb.sv ====
`timescale 1ns/1ps
`include "modmul_settings.svh"

module modmul_tb;
    import modmul_pkg::*;

    localparam logic [63:0] MODULUS = 64'h7fff_ffff;

    logic                      clk = 1'b0;
    logic                      aclr;
    cmd_t                      i_cmd;
    word_t                     i_t_data;
    logic                      ready;
    logic [`MM_MEM_ADDR_W-1:0] mem_addr;
    logic                      mem_rden;
    logic                      mem_wren;
    word_t                     mem_wdata;
    word_t                     mem_rdata = '0;

    word_t                     mem [512];
    logic                      poke_en = 1'b0;
    logic [`MM_MEM_ADDR_W-1:0] poke_addr = '0;
    word_t                     poke_data = '0;

    logic [8*24-1:0]           cur_name = '0;
    logic [31:0]               cur_exp = '0;
    int                        checks;
    int                        fails;
    int                        stores = 0;
    logic                      aborted = 1'b0;
    logic [31:0]               rng = 32'hab0e;

    always #10 clk = ~clk;

    modmul_top modmul_top_inst (
        .clk         (clk),
        .aclr        (aclr),
        .i_cmd       (i_cmd),
        .o_ready     (ready),
        .i_t_data    (i_t_data),
        .o_mem_addr  (mem_addr),
        .o_mem_rden  (mem_rden),
        .o_mem_wren  (mem_wren),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    modmul_checker modmul_checker_inst (
        .clk         (clk),
        .aclr        (aclr),
        .i_ready     (ready),
        .i_mem_rden  (mem_rden),
        .i_mem_wren  (mem_wren),
        .i_mem_addr  (mem_addr),
        .i_mem_wdata (mem_wdata),
        .i_name      (cur_name),
        .i_expected  (cur_exp),
        .o_checks    (checks),
        .o_fails     (fails)
    );

    // memory with one cycle of read latency, the bench can also poke words into it
    always @(posedge clk) begin
        if (aclr) begin
            for (int a = 0; a < 512; a++) begin
                mem[a] <= word_t'((a * 7) ^ (a >> 3));
            end
            mem_rdata <= '0;
        end else begin
            if (mem_rden) begin
                mem_rdata <= mem[mem_addr];
            end
            if (mem_wren) begin
                mem[mem_addr] <= mem_wdata;
            end else if (poke_en) begin
                mem[poke_addr] <= poke_data;
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference product modulo 2^31-1 in plain 64-bit arithmetic
    function automatic logic [31:0] mulmod(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] p;
        p = {32'd0, a} * {32'd0, b};
        return 32'(p % MODULUS);
    endfunction

    task automatic wait_ready();
        logic seen;
        seen = 1'b0;
        for (int c = 0; c < 200 && !aborted; c++) begin
            @(negedge clk);
            if (ready) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen && !aborted) begin
            aborted = 1'b1;
            $display("o_ready stayed low for 200 cycles during %0s", cur_name);
        end
    endtask

    // the command is taken at the second edge, T words follow one per cycle after it
    task automatic send_command(input cmd_t cmd, input logic [31:0] t);
        wait_ready();
        if (!aborted) begin
            @(posedge clk);
            i_cmd <= cmd;
            @(posedge clk);
            i_cmd    <= CMD_NOP;
            i_t_data <= t[7:0];
            for (int k = 1; k < `MM_N_WORDS; k++) begin
                @(posedge clk);
                i_t_data <= t[k*8 +: 8];
            end
            @(posedge clk);
            i_t_data <= '0;
        end
    endtask

    task automatic run_store(input logic [31:0] expected);
        wait_ready();
        cur_exp = expected;
        stores++;
        send_command(CMD_STORE, 32'd0);
    endtask

    task automatic poke_value(input logic [31:0] v);
        for (int k = 0; k < `MM_N_WORDS; k++) begin
            @(posedge clk);
            poke_en   <= 1'b1;
            poke_addr <= 9'(`MM_PRELOAD_BASE + k);
            poke_data <= v[k*8 +: 8];
        end
        @(posedge clk);
        poke_en <= 1'b0;
    endtask

    // twenty random multiplies and squares starting from r equal to one
    task automatic run_random(input int count);
        logic [31:0] model;
        logic [31:0] t;
        send_command(CMD_RESET_RESULT, 32'd0);
        model = 32'd1;
        for (int i = 0; i < count && !aborted; i++) begin
            rng = xorshift(rng);
            t   = {1'b0, rng[30:0]};
            if (rng[31]) begin
                send_command(CMD_MULT, t);
                model = mulmod(model, t);
            end else begin
                send_command(CMD_SQUARE, 32'd0);
                model = mulmod(model, model);
            end
            run_store(model);
        end
    endtask

    task automatic run_test(input logic [8*8-1:0] cmd_s, input logic [31:0] op,
                            input logic [31:0] expected);
        if (cmd_s == 64'("STORE")) begin
            run_store(expected);
        end else if (cmd_s == 64'("RESET")) begin
            send_command(CMD_RESET_RESULT, 32'd0);
            run_store(expected);
        end else if (cmd_s == 64'("PRELOAD")) begin
            wait_ready();
            poke_value(op);
            send_command(CMD_PRELOAD, 32'd0);
            run_store(expected);
        end else if (cmd_s == 64'("MULT")) begin
            send_command(CMD_MULT, op);
            run_store(expected);
        end else if (cmd_s == 64'("SQUARE")) begin
            send_command(CMD_SQUARE, 32'd0);
            run_store(expected);
        end else if (cmd_s == 64'("RANDOM")) begin
            run_random(int'(op));
        end else begin
            aborted = 1'b1;
            $display("unknown command %0s in trace line %0s", cmd_s, cur_name);
        end
    endtask

    initial begin
        int              fd;
        int              n;
        logic [8*96-1:0] line;
        logic [8*24-1:0] name;
        logic [8*8-1:0]  cmd_s;
        logic [31:0]     op;
        logic [31:0]     expected;
        aclr     = 1'b1;
        i_cmd    = CMD_NOP;
        i_t_data = '0;
        repeat (2) @(posedge clk);
        aclr <= 1'b0;
        fd = $fopen("bench/modmul_trace.txt", "r");
        if (fd == 0) begin
            aborted = 1'b1;
            $display("could not open the trace file bench/modmul_trace.txt");
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h", name, cmd_s, op, expected);
                // comment lines start with a lone hash token
                if (n == 4 && name != 192'("#")) begin
                    cur_name = name;
                    run_test(cmd_s, op, expected);
                end
            end
            $fclose(fd);
        end
        wait_ready();
        repeat (2) @(posedge clk);
        $display("tests passed %0d, failed %0d", checks - fails, fails);
        if (!aborted && checks != stores + 1) begin
            $display("checker saw %0d results but %0d were expected", checks, stores + 1);
        end
        if (aborted || fails != 0 || checks != stores + 1) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

// ==== bench/modmul_trace.txt ====
# name command operand expected
# operand and expected are hex, RANDOM takes the step count as its operand
after_reset STORE 00000000 00000000
set_one RESET 00000000 00000001
preload_a PRELOAD 12345678 12345678
mult_small MULT 00000003 369d0368
preload_pm1 PRELOAD 7ffffffe 7ffffffe
mult_pm1 MULT 7ffffffe 00000001
preload_pm1b PRELOAD 7ffffffe 7ffffffe
square_pm1 SQUARE 00000000 00000001
preload_c PRELOAD 00010000 00010000
square_c SQUARE 00000000 00000002
square_c2 SQUARE 00000000 00000004
mult_2p30 MULT 40000000 00000002
mult_p MULT 7fffffff 00000000
set_one_b RESET 00000000 00000001
mult_five MULT 00000005 00000005
square_five SQUARE 00000000 00000019
mult_max MULT 7ffffffe 7fffffe6
preload_d PRELOAD 0abcdef1 0abcdef1
store_again STORE 00000000 0abcdef1
random_chain RANDOM 00000014 00000000

// ==== sim.f ====
+incdir+logic
logic/modmul_pkg.sv
logic/mm_bus_if.sv
logic/mm_sequencer.sv
logic/mac_array.sv
logic/mersenne_fold.sv
logic/modmul_top.sv
bench/modmul_checker.sv
bench/modmul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module modmul_tb \
    --Mdir obj_dir -o modmul_sim
./obj_dir/modmul_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log
